// File: hw/csr_pkg.sv
package csr_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xdata_t;
    typedef logic [xlen-1:0] pc_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [31:0]     inst_t;

    // machine-mode csr addresses
    localparam csr_addr_t csr_mstatus   = 12'h300;
    localparam csr_addr_t csr_misa      = 12'h301;
    localparam csr_addr_t csr_mie       = 12'h304;
    localparam csr_addr_t csr_mtvec     = 12'h305;
    localparam csr_addr_t csr_mscratch  = 12'h340;
    localparam csr_addr_t csr_mepc      = 12'h341;
    localparam csr_addr_t csr_mcause    = 12'h342;
    localparam csr_addr_t csr_mip       = 12'h344;
    localparam csr_addr_t csr_mcycle    = 12'hB00;
    localparam csr_addr_t csr_minstret  = 12'hB02;
    localparam csr_addr_t csr_mvendorid = 12'hF11;
    localparam csr_addr_t csr_marchid   = 12'hF12;
    localparam csr_addr_t csr_mimpid    = 12'hF13;
    localparam csr_addr_t csr_mhartid   = 12'hF14;

    // mxl = 2, I extension
    localparam xdata_t misa_value      = 64'h8000_0000_0000_0100;
    localparam xdata_t mvendorid_value = 64'h0;
    localparam xdata_t marchid_value   = 64'h0;
    localparam xdata_t mimpid_value    = 64'h0;
    localparam xdata_t mhartid_value   = 64'h0;

    localparam xdata_t mstatus_reset = 64'h1800;
    localparam xdata_t mstatus_wmask = 64'h88;
    localparam xdata_t mie_reset     = 64'h80;
    localparam xdata_t irq_mask      = 64'h80;

    localparam xdata_t cause_ecall  = 64'd11;
    localparam xdata_t cause_ebreak = 64'd3;
    localparam xdata_t cause_mtimer = 64'h8000_0000_0000_0007;

    // instruction fields of the SYSTEM group
    localparam logic [6:0] opcode_system = 7'b1110011;
    localparam csr_addr_t  funct12_ecall  = 12'h000;
    localparam csr_addr_t  funct12_ebreak = 12'h001;
    localparam csr_addr_t  funct12_mret   = 12'h302;

    typedef enum logic [1:0] {
        op_none,
        op_write,
        op_set,
        op_clear
    } csr_op_e;

    typedef enum logic [1:0] {
        ev_none,
        ev_ecall,
        ev_ebreak,
        ev_mret
    } sys_event_e;

endpackage

// File: hw/csr_req_if.sv
`timescale 1ns/1ps

interface csr_req_if import csr_pkg::*; ();

    logic       valid;
    csr_op_e    op;
    csr_addr_t  addr;
    xdata_t     wdata;
    sys_event_e sys_event;
    pc_t        pc;

    modport decoder (
        output valid,
        output op,
        output addr,
        output wdata,
        output sys_event,
        output pc
    );

    modport file (
        input valid,
        input op,
        input addr,
        input wdata,
        input sys_event,
        input pc
    );

endinterface

// File: hw/csr_decoder.sv
`timescale 1ns/1ps

module csr_decoder import csr_pkg::*; (
    input  logic    inst_valid,
    input  inst_t   inst,
    input  pc_t     pc,
    input  xdata_t  rs1_data,
    csr_req_if.decoder req
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1_idx;
    csr_addr_t  funct12;
    logic       is_system;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign rs1_idx   = inst[19:15];
    assign funct12   = inst[31:20];
    assign is_system = (opcode == opcode_system);

    // every valid word retires, system or not
    assign req.valid = inst_valid;
    assign req.addr  = funct12;
    assign req.pc    = pc;

    // immediate forms take the rs1 field as a 5-bit value
    assign req.wdata = funct3[2] ? {{(xlen-5){1'b0}}, rs1_idx} : rs1_data;

    always_comb begin
        req.op        = op_none;
        req.sys_event = ev_none;
        if (is_system) begin
            case (funct3)
                3'b001, 3'b101: begin
                    req.op = op_write;
                end
                3'b010, 3'b110: begin
                    req.op = op_set;
                end
                3'b011, 3'b111: begin
                    req.op = op_clear;
                end
                3'b000: begin
                    case (funct12)
                        funct12_ecall:  req.sys_event = ev_ecall;
                        funct12_ebreak: req.sys_event = ev_ebreak;
                        funct12_mret:   req.sys_event = ev_mret;
                        default:        req.sys_event = ev_none;
                    endcase
                end
                default: begin
                    req.op = op_none;
                end
            endcase
        end
    end

endmodule

// File: hw/csr_file.sv
`timescale 1ns/1ps

module csr_file import csr_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    csr_req_if.file req,
    input  logic   timer_irq,
    output xdata_t rdata,
    output logic   irq_pending,
    output logic   redirect_valid,
    output pc_t    redirect_pc
);

    xdata_t mstatus_q;
    xdata_t mtvec_q;
    xdata_t mepc_q;
    xdata_t mcause_q;
    xdata_t mie_q;
    xdata_t mscratch_q;
    xdata_t mcycle_q;
    xdata_t minstret_q;
    xdata_t mip_val;

    logic   take_irq;
    logic   take_exc;
    logic   take_ret;
    logic   trap_entry;
    logic   do_csr;
    xdata_t trap_cause;
    xdata_t csr_new;

    // mip is not stored, only the timer line shows through
    assign mip_val = timer_irq ? irq_mask : '0;

    assign irq_pending = mstatus_q[3] & mie_q[7] & timer_irq;

    // interrupt wins over whatever the instruction would have done
    assign take_irq   = req.valid & irq_pending;
    assign take_exc   = req.valid & ~irq_pending &
                        (req.sys_event == ev_ecall || req.sys_event == ev_ebreak);
    assign take_ret   = req.valid & ~irq_pending & (req.sys_event == ev_mret);
    assign do_csr     = req.valid & ~irq_pending & (req.op != op_none);
    assign trap_entry = take_irq | take_exc;

    always_comb begin
        if (take_irq) begin
            trap_cause = cause_mtimer;
        end else if (req.sys_event == ev_ebreak) begin
            trap_cause = cause_ebreak;
        end else begin
            trap_cause = cause_ecall;
        end
    end

    // read mux, old values
    always_comb begin
        case (req.addr)
            csr_mstatus:   rdata = mstatus_q;
            csr_misa:      rdata = misa_value;
            csr_mie:       rdata = mie_q;
            csr_mtvec:     rdata = mtvec_q;
            csr_mscratch:  rdata = mscratch_q;
            csr_mepc:      rdata = mepc_q;
            csr_mcause:    rdata = mcause_q;
            csr_mip:       rdata = mip_val;
            csr_mcycle:    rdata = mcycle_q;
            csr_minstret:  rdata = minstret_q;
            csr_mvendorid: rdata = mvendorid_value;
            csr_marchid:   rdata = marchid_value;
            csr_mimpid:    rdata = mimpid_value;
            csr_mhartid:   rdata = mhartid_value;
            default:       rdata = '0;
        endcase
    end

    always_comb begin
        case (req.op)
            op_write: csr_new = req.wdata;
            op_set:   csr_new = rdata | req.wdata;
            op_clear: csr_new = rdata & ~req.wdata;
            default:  csr_new = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= mstatus_reset;
        end else if (trap_entry) begin
            mstatus_q[7] <= mstatus_q[3];
            mstatus_q[3] <= 1'b0;
        end else if (take_ret) begin
            mstatus_q[3] <= mstatus_q[7];
            mstatus_q[7] <= 1'b1;
        end else if (do_csr && req.addr == csr_mstatus) begin
            // MPP stays at machine mode
            mstatus_q <= (csr_new & mstatus_wmask) | mstatus_reset;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (trap_entry) begin
            mepc_q   <= req.pc;
            mcause_q <= trap_cause;
        end else if (do_csr) begin
            if (req.addr == csr_mepc) begin
                mepc_q <= csr_new;
            end
            if (req.addr == csr_mcause) begin
                mcause_q <= csr_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q    <= '0;
            mie_q      <= mie_reset;
            mscratch_q <= '0;
        end else if (do_csr) begin
            // direct mode only
            if (req.addr == csr_mtvec) begin
                mtvec_q <= csr_new & ~xdata_t'(3);
            end
            if (req.addr == csr_mie) begin
                mie_q <= csr_new & irq_mask;
            end
            if (req.addr == csr_mscratch) begin
                mscratch_q <= csr_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q <= '0;
        end else if (do_csr && req.addr == csr_mcycle) begin
            mcycle_q <= csr_new;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
        end
    end

    // interrupted instructions do not retire
    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_q <= '0;
        end else if (do_csr && req.addr == csr_minstret) begin
            minstret_q <= csr_new;
        end else if (req.valid && !irq_pending) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    assign redirect_valid = trap_entry | take_ret;

    always_comb begin
        if (trap_entry) begin
            redirect_pc = mtvec_q;
        end else if (take_ret) begin
            redirect_pc = mepc_q;
        end else begin
            redirect_pc = '0;
        end
    end

endmodule

// File: hw/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top import csr_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   inst_valid,
    input  inst_t  inst,
    input  pc_t    pc,
    input  xdata_t rs1_data,
    input  logic   timer_irq,

    output xdata_t csr_rdata,
    output logic   irq_pending,
    output logic   redirect_valid,
    output pc_t    redirect_pc
);

    csr_req_if req_if ();

    csr_decoder dec_i (
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .req        (req_if.decoder)
    );

    csr_file file_i (
        .clk            (clk),
        .rst            (rst),
        .req            (req_if.file),
        .timer_irq      (timer_irq),
        .rdata          (csr_rdata),
        .irq_pending    (irq_pending),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// File: sim/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    localparam int num_cycles     = 3000;
    localparam int timeout_cycles = num_cycles + 1000;

    localparam int kind_csr    = 0;
    localparam int kind_ecall  = 1;
    localparam int kind_ebreak = 2;
    localparam int kind_mret   = 3;
    localparam int kind_other  = 4;

    logic   clk;
    logic   rst;
    logic   inst_valid;
    inst_t  inst;
    pc_t    pc;
    xdata_t rs1_data;
    logic   timer_irq;
    xdata_t csr_rdata;
    logic   irq_pending;
    logic   redirect_valid;
    pc_t    redirect_pc;

    // stimulus fields of the current cycle
    int         cur_kind;
    logic [2:0] cur_f3;
    csr_addr_t  cur_addr;
    logic [4:0] cur_rs1;

    // reference copies of the registers
    xdata_t m_mstatus;
    xdata_t m_mtvec;
    xdata_t m_mepc;
    xdata_t m_mcause;
    xdata_t m_mie;
    xdata_t m_mscratch;
    xdata_t m_mcycle;
    xdata_t m_minstret;

    int errors;
    int checks;
    int cycle_count;

    // 12'h7c0 is not implemented and must read zero
    csr_addr_t addr_list [0:14] = '{
        csr_mstatus, csr_misa, csr_mie, csr_mtvec, csr_mscratch,
        csr_mepc, csr_mcause, csr_mip, csr_mcycle, csr_minstret,
        csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, 12'h7C0
    };

    csr_unit_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .timer_irq      (timer_irq),
        .csr_rdata      (csr_rdata),
        .irq_pending    (irq_pending),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic xdata_t read_model(csr_addr_t a);
        case (a)
            csr_mstatus:  return m_mstatus;
            csr_misa:     return 64'h8000_0000_0000_0100;
            csr_mie:      return m_mie;
            csr_mtvec:    return m_mtvec;
            csr_mscratch: return m_mscratch;
            csr_mepc:     return m_mepc;
            csr_mcause:   return m_mcause;
            csr_mip:      return timer_irq ? 64'h80 : 64'h0;
            csr_mcycle:   return m_mcycle;
            csr_minstret: return m_minstret;
            default:      return 64'h0;
        endcase
    endfunction

    function automatic void reset_model();
        m_mstatus  = 64'h1800;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mie      = 64'h80;
        m_mscratch = '0;
        m_mcycle   = '0;
        m_minstret = '0;
    endfunction

    function automatic void drive_random();
        int sel;
        logic [4:0] rd_idx;
        sel    = $urandom_range(0, 19);
        rd_idx = 5'($urandom);
        cur_f3   = 3'b000;
        cur_addr = '0;
        cur_rs1  = 5'($urandom);
        if (sel < 12) begin
            cur_kind = kind_csr;
            cur_f3   = 3'($urandom_range(1, 6));
            if (cur_f3 >= 3'd4) begin
                cur_f3 = cur_f3 + 3'd1;
            end
            // mstatus more often so that interrupts get enabled
            if ($urandom_range(0, 3) == 0) begin
                cur_addr = csr_mstatus;
            end else begin
                cur_addr = addr_list[$urandom_range(0, 14)];
            end
            inst = {cur_addr, cur_rs1, cur_f3, rd_idx, 7'b1110011};
        end else if (sel == 12) begin
            cur_kind = kind_ecall;
            inst     = 32'h0000_0073;
        end else if (sel == 13) begin
            cur_kind = kind_ebreak;
            inst     = 32'h0010_0073;
        end else if (sel < 16) begin
            cur_kind = kind_mret;
            inst     = 32'h3020_0073;
        end else begin
            cur_kind = kind_other;
            inst     = {25'($urandom), 7'b0010011};
        end
        inst_valid = ($urandom_range(0, 99) < 70);
        pc         = {32'($urandom), 32'($urandom)};
        rs1_data   = {32'($urandom), 32'($urandom)};
        if ($urandom_range(0, 39) == 0) begin
            timer_irq = ~timer_irq;
        end
    endfunction

    function automatic void check_outputs();
        logic   exp_pend;
        logic   exp_rv;
        pc_t    exp_rpc;
        xdata_t exp_rdata;
        exp_pend = m_mstatus[3] & m_mie[7] & timer_irq;
        exp_rv   = 1'b0;
        exp_rpc  = '0;
        if (inst_valid) begin
            if (exp_pend || cur_kind == kind_ecall || cur_kind == kind_ebreak) begin
                exp_rv  = 1'b1;
                exp_rpc = m_mtvec;
            end else if (cur_kind == kind_mret) begin
                exp_rv  = 1'b1;
                exp_rpc = m_mepc;
            end
        end
        checks = checks + 3;
        assert (irq_pending === exp_pend) else begin
            errors++;
            $display("FAILED irq_pending expected %h got %h", exp_pend, irq_pending);
        end
        assert (redirect_valid === exp_rv) else begin
            errors++;
            $display("FAILED redirect_valid expected %h got %h", exp_rv, redirect_valid);
        end
        assert (redirect_pc === exp_rpc) else begin
            errors++;
            $display("FAILED redirect_pc expected %h got %h", exp_rpc, redirect_pc);
        end
        if (cur_kind == kind_csr) begin
            exp_rdata = read_model(cur_addr);
            checks++;
            assert (csr_rdata === exp_rdata) else begin
                errors++;
                $display("FAILED csr_rdata (addr %h) expected %h got %h",
                         cur_addr, exp_rdata, csr_rdata);
            end
        end
    endfunction

    // next state, as the registers look after the coming edge
    function automatic void step_model();
        logic   pend;
        logic   csr_wr;
        xdata_t old_val;
        xdata_t wsrc;
        xdata_t new_val;
        pend    = m_mstatus[3] & m_mie[7] & timer_irq;
        old_val = read_model(cur_addr);
        wsrc    = cur_f3[2] ? {59'b0, cur_rs1} : rs1_data;
        case (cur_f3[1:0])
            2'b01:   new_val = wsrc;
            2'b10:   new_val = old_val | wsrc;
            2'b11:   new_val = old_val & ~wsrc;
            default: new_val = old_val;
        endcase
        csr_wr = inst_valid && !pend && cur_kind == kind_csr;

        if (csr_wr && cur_addr == csr_mcycle) begin
            m_mcycle = new_val;
        end else begin
            m_mcycle = m_mcycle + 64'd1;
        end
        if (csr_wr && cur_addr == csr_minstret) begin
            m_minstret = new_val;
        end else if (inst_valid && !pend) begin
            m_minstret = m_minstret + 64'd1;
        end

        if (inst_valid && (pend || cur_kind == kind_ecall || cur_kind == kind_ebreak)) begin
            m_mepc = pc;
            if (pend) begin
                m_mcause = cause_mtimer;
            end else if (cur_kind == kind_ecall) begin
                m_mcause = cause_ecall;
            end else begin
                m_mcause = cause_ebreak;
            end
            m_mstatus[7] = m_mstatus[3];
            m_mstatus[3] = 1'b0;
        end else if (inst_valid && cur_kind == kind_mret) begin
            m_mstatus[3] = m_mstatus[7];
            m_mstatus[7] = 1'b1;
        end else if (csr_wr) begin
            case (cur_addr)
                csr_mstatus:  m_mstatus  = (new_val & 64'h88) | 64'h1800;
                csr_mtvec:    m_mtvec    = new_val & ~64'h3;
                csr_mie:      m_mie      = new_val & 64'h80;
                csr_mscratch: m_mscratch = new_val;
                csr_mepc:     m_mepc     = new_val;
                csr_mcause:   m_mcause   = new_val;
                default:      ;
            endcase
        end
    endfunction

    initial begin
        void'($urandom(32'h1817_6329));
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        rs1_data   = '0;
        timer_irq  = 1'b0;
        cur_kind   = kind_other;
        cur_f3     = '0;
        cur_addr   = '0;
        cur_rs1    = '0;
        reset_model();
        repeat (5) @(posedge clk);
        for (int i = 0; i < num_cycles; i++) begin
            #1;
            rst = 1'b0;
            drive_random();
            #4;
            check_outputs();
            step_model();
            @(posedge clk);
        end
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: compile.f
hw/csr_pkg.sv
hw/csr_req_if.sv
hw/csr_decoder.sv
hw/csr_file.sv
hw/csr_unit_top.sv
sim/csr_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f compile.f \
    --top-module csr_unit_tb -o csr_unit_sim \
    && ./obj_dir/csr_unit_sim | tee /dev/stderr | grep -F "TEST RESULT: PASS" > /dev/null \
    && exit 0 \
    || exit 1
